// File: filelist.f
+incdir+hdl
hdl/cpuPkg.sv
hdl/regFile.sv
hdl/insnDecoder.sv
hdl/execUnit.sv
hdl/cpuCore.sv
hdl/wordMemory.sv
hdl/cpuSystem.sv
tb/cpuSystem_props.sv
tb/cpuSystem_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module cpuSystem_tb \
    -f filelist.f -o simv
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
exit 0

// File: tb/cpuSystem_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_macros.svh"

module cpuSystem_tb;

    logic          clk;
    logic          reset_n;
    logic          haltRequest;
    logic          loadEnable;
    cpuPkg::word_t loadAddr;
    cpuPkg::word_t loadData;
    logic          halted;
    logic          storeStrobe;
    cpuPkg::word_t storeAddr;
    cpuPkg::word_t storeData;

    cpuPkg::word_t prog [$];              // Program image from address 0
    cpuPkg::word_t expAddr [$];           // Expected stores in order
    cpuPkg::word_t expData [$];
    cpuPkg::word_t modelMem [0:`MEM_DEPTH-1];
    cpuPkg::word_t modelReg [1:14];
    cpuPkg::word_t modelPc;
    int            cycleCount;
    int            cycleLimit;

    cpuSystem u_dut (
        .clk         (clk),
        .reset_n     (reset_n),
        .haltRequest (haltRequest),
        .loadEnable  (loadEnable),
        .loadAddr    (loadAddr),
        .loadData    (loadData),
        .halted      (halted),
        .storeStrobe (storeStrobe),
        .storeAddr   (storeAddr),
        .storeData   (storeData)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abortRun();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input cpuPkg::word_t got,
                             input cpuPkg::word_t exp);
        if (got !== exp) begin
            $display("ERR time %0t %s got %h expected %h", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkHalt(input logic exp);
        if (halted !== exp) begin
            $display("ERR time %0t halted got %b expected %b", $time, halted, exp);
            abortRun();
        end
    endtask

    // Timeout guard with a limit per phase
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles, the core did not finish", cycleCount);
            abortRun();
        end
    end

    // Compare each store with the next expected one
    always @(negedge clk) begin
        if (reset_n && storeStrobe) begin
            if (expAddr.size() == 0) begin
                $display("Unexpected store at time %0t to %h", $time, storeAddr);
                abortRun();
            end else begin
                checkWord("storeAddr", storeAddr, expAddr.pop_front());
                checkWord("storeData", storeData, expData.pop_front());
            end
        end
    end

    function automatic cpuPkg::word_t encodeInsn(input logic kind, input logic storing,
            input logic deref, input int z, input int x, input int y,
            input cpuPkg::opcode_t op, input logic [11:0] imm);
        cpuPkg::insn_t f;
        f.reserved = 1'b0;
        f.kind     = kind;
        f.storing  = storing;
        f.derefRhs = deref;
        f.z        = cpuPkg::regIndex_t'(z);
        f.x        = cpuPkg::regIndex_t'(x);
        f.y        = cpuPkg::regIndex_t'(y);
        f.opcode   = op;
        f.imm      = imm;
        return cpuPkg::word_t'(f);
    endfunction

    function automatic cpuPkg::word_t readReg(input cpuPkg::regIndex_t i);
        if (i == 4'd0) return '0;
        if (i == 4'd15) return modelPc + 32'd1;  // r15 is pc+1
        return modelReg[i];
    endfunction

    // One instruction of the reference model that returns 1 on the illegal word
    function automatic logic refStep(output logic stored, output cpuPkg::word_t sAddr,
                                     output cpuPkg::word_t sData);
        cpuPkg::word_t insn;
        cpuPkg::insn_t f;
        cpuPkg::word_t imm;
        cpuPkg::word_t x;
        cpuPkg::word_t z;
        cpuPkg::word_t a;
        cpuPkg::word_t b;
        cpuPkg::word_t r;
        cpuPkg::word_t wb;
        insn = modelMem[modelPc[`ADDR_BITS-1:0]];
        stored = 1'b0;
        sAddr = '0;
        sData = '0;
        if (insn == `ILLEGAL_INSN) return 1'b1;
        f = cpuPkg::insn_t'(insn);
        imm = {{20{f.imm[11]}}, f.imm};
        x = readReg(f.x);
        z = readReg(f.z);
        a = f.kind ? imm : readReg(f.y);  // Second operand
        b = f.kind ? readReg(f.y) : imm;  // Addend
        case (f.opcode)
            cpuPkg::opOr:     r = x | a;
            cpuPkg::opAnd:    r = x & a;
            cpuPkg::opAdd:    r = x + a;
            cpuPkg::opMul:    r = x * a;
            cpuPkg::opShl:    r = x << a;
            cpuPkg::opLt:     r = ($signed(x) < $signed(a)) ? '1 : '0;
            cpuPkg::opEq:     r = (x == a) ? '1 : '0;
            cpuPkg::opGt:     r = ($signed(x) > $signed(a)) ? '1 : '0;
            cpuPkg::opAndNot: r = x & ~a;
            cpuPkg::opXor:    r = x ^ a;
            cpuPkg::opSub:    r = x - a;
            cpuPkg::opXnor:   r = ~(x ^ a);
            cpuPkg::opShr:    r = x >> a;
            cpuPkg::opNe:     r = (x != a) ? '1 : '0;
            default:          r = '0;         // Reserved opcodes
        endcase
        r = r + b;
        if (f.storing) begin
            stored = 1'b1;
            sAddr = f.derefRhs ? r : z;
            sData = f.derefRhs ? z : r;
            modelMem[sAddr[`ADDR_BITS-1:0]] = sData;
            modelPc = modelPc + 32'd1;
        end else begin
            wb = f.derefRhs ? modelMem[r[`ADDR_BITS-1:0]] : r;
            if (f.z == 4'd15) begin
                modelPc = wb;                 // Jump
            end else begin
                if (f.z != 4'd0) modelReg[f.z] = wb;
                modelPc = modelPc + 32'd1;
            end
        end
        return 1'b0;
    endfunction

    task automatic runModel();
        logic stored;
        cpuPkg::word_t sAddr;
        cpuPkg::word_t sData;
        int steps;
        modelPc = `RESET_VECTOR;
        expAddr.delete();
        expData.delete();
        steps = 0;
        while (!refStep(stored, sAddr, sData)) begin
            steps++;
            if (stored) begin
                expAddr.push_back(sAddr);
                expData.push_back(sData);
            end
            if (steps > 500) begin
                $display("Reference model never reached the illegal word");
                abortRun();
            end
        end
        cycleCount = 0;
        cycleLimit = 6 * (steps + 1) + 40;
    endtask

    task automatic loadWord(input cpuPkg::word_t addr, input cpuPkg::word_t data);
        @(posedge clk);
        #1;
        loadEnable = 1'b1;
        loadAddr = addr;
        loadData = data;
        modelMem[addr[`ADDR_BITS-1:0]] = data;
    endtask

    task automatic runProgram(input logic holdHalt);
        @(posedge clk);
        #1;
        reset_n = 1'b0;
        cycleCount = 0;
        cycleLimit = prog.size() + 400;
        for (int a = 'h700; a < 'h800; a++) begin
            loadWord(a, (a * 32'h9E37_79B9) ^ 32'h0F0F_1234);  // Data window
        end
        foreach (prog[i]) loadWord(i, prog[i]);
        @(posedge clk);
        #1;
        loadEnable = 1'b0;
        haltRequest = holdHalt;
        repeat (8) @(posedge clk);
        @(negedge clk);
        checkHalt(1'b0);
        if (holdHalt) begin
            @(posedge clk);
            #1;
            reset_n = 1'b1;
            repeat (40) @(negedge clk);  // Core held idle so a store is flagged
            checkHalt(1'b0);
            runModel();
            @(posedge clk);
            #1;
            haltRequest = 1'b0;
        end else begin
            runModel();
            @(posedge clk);
            #1;
            reset_n = 1'b1;
        end
        while (halted !== 1'b1) @(negedge clk);
        repeat (4) @(negedge clk);
        if (expAddr.size() != 0) begin
            $display("%0d expected stores never happened", expAddr.size());
            abortRun();
        end
        checkHalt(1'b1);
    endtask

    initial begin
        void'($urandom(72));
        reset_n = 1'b0;
        haltRequest = 1'b0;
        loadEnable = 1'b0;
        loadAddr = '0;
        loadData = '0;
        cycleCount = 0;
        cycleLimit = 1000;

        // All opcodes in both forms stored through r4
        prog = {encodeInsn(0, 0, 0, 1, 0, 0, cpuPkg::opOr, 12'h5A3),
                encodeInsn(0, 0, 0, 2, 0, 0, cpuPkg::opOr, 12'hFF9),
                encodeInsn(0, 0, 0, 3, 0, 0, cpuPkg::opOr, 12'h004),
                encodeInsn(0, 0, 0, 4, 0, 0, cpuPkg::opOr, 12'h7F0)};
        for (int op = 0; op < 16; op++) begin
            for (int k = 0; k < 2; k++) begin
                prog.push_back(encodeInsn(k[0], 1, 0, 4, k ? 2 : 1, 3,
                    cpuPkg::opcode_t'(4'(op)), k ? 12'h003 : 12'hFFE));
            end
        end
        prog.push_back(`ILLEGAL_INSN);
        runProgram(1'b0);

        // Loads and both store routings
        prog = {encodeInsn(0, 0, 1, 6, 0, 0, cpuPkg::opOr, 12'h703),
                encodeInsn(0, 1, 1, 6, 0, 0, cpuPkg::opOr, 12'h710),
                encodeInsn(0, 0, 0, 8, 0, 0, cpuPkg::opOr, 12'h720),
                encodeInsn(0, 1, 0, 8, 6, 0, cpuPkg::opAdd, 12'h005),
                encodeInsn(0, 0, 1, 9, 0, 0, cpuPkg::opOr, 12'h710),
                encodeInsn(0, 1, 1, 9, 0, 0, cpuPkg::opOr, 12'h711),
                encodeInsn(0, 0, 1, 10, 8, 0, cpuPkg::opAdd, 12'h000),
                encodeInsn(1, 1, 1, 10, 8, 0, cpuPkg::opSub, 12'h010),
                `ILLEGAL_INSN};
        runProgram(1'b0);

        // Jumps taken and not taken plus r0 and r15 reads
        prog = {encodeInsn(0, 0, 0, 1, 0, 0, cpuPkg::opOr, 12'h001),
                encodeInsn(0, 0, 0, 15, 15, 0, cpuPkg::opAdd, 12'h001),
                encodeInsn(0, 1, 1, 1, 0, 0, cpuPkg::opOr, 12'h740),
                encodeInsn(0, 1, 1, 15, 0, 0, cpuPkg::opOr, 12'h731),
                encodeInsn(0, 0, 0, 0, 0, 0, cpuPkg::opOr, 12'h055),
                encodeInsn(0, 1, 1, 0, 0, 0, cpuPkg::opOr, 12'h730),
                encodeInsn(1, 0, 0, 3, 1, 0, cpuPkg::opEq, 12'h001),
                encodeInsn(1, 0, 0, 5, 3, 0, cpuPkg::opAnd, 12'h002),
                encodeInsn(0, 0, 0, 15, 15, 5, cpuPkg::opAdd, 12'h000),
                encodeInsn(0, 1, 1, 1, 0, 0, cpuPkg::opOr, 12'h741),
                encodeInsn(0, 1, 1, 1, 0, 0, cpuPkg::opOr, 12'h742),
                encodeInsn(1, 0, 0, 6, 1, 0, cpuPkg::opEq, 12'h005),
                encodeInsn(1, 0, 0, 7, 6, 0, cpuPkg::opAnd, 12'h002),
                encodeInsn(0, 0, 0, 15, 15, 7, cpuPkg::opAdd, 12'h000),
                encodeInsn(0, 1, 1, 1, 0, 0, cpuPkg::opOr, 12'h743),
                `ILLEGAL_INSN};
        runProgram(1'b0);

        // Random mix after every register is set up
        prog.delete();
        for (int r = 1; r < 15; r++) begin
            prog.push_back(encodeInsn(0, 0, 0, r, 0, 0, cpuPkg::opOr, 12'($urandom)));
        end
        for (int i = 0; i < 40; i++) begin
            case ($urandom % 4)
                0, 1: prog.push_back(encodeInsn(1'($urandom), 0, 0, $urandom % 14 + 1,
                          $urandom % 16, $urandom % 16, cpuPkg::opcode_t'(4'($urandom)),
                          12'($urandom)));
                2: prog.push_back(encodeInsn(0, 0, 1, $urandom % 14 + 1, 0, 0,
                          cpuPkg::opOr, 12'(32'h700 + $urandom % 256)));
                default: prog.push_back(encodeInsn(0, 1, 1, $urandom % 16, 0, 0,
                          cpuPkg::opOr, 12'(32'h700 + $urandom % 256)));
            endcase
        end
        prog.push_back(`ILLEGAL_INSN);
        runProgram(1'b0);

        // Halt request held across reset release
        prog = {encodeInsn(0, 0, 0, 2, 0, 0, cpuPkg::opOr, 12'h123),
                encodeInsn(0, 1, 1, 2, 0, 0, cpuPkg::opOr, 12'h750),
                encodeInsn(1, 1, 1, 2, 2, 0, cpuPkg::opMul, 12'h751),
                `ILLEGAL_INSN};
        runProgram(1'b1);

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/cpuSystem_props.sv
`timescale 1ns/1ns
`default_nettype none

module cpuSystem_props (
    input wire logic clk,
    input wire logic reset_n,
    input wire logic dataStrobe,
    input wire logic halted
);

    // Strobe is a single-cycle pulse
    strobeSingle: assert property (@(posedge clk) disable iff (!reset_n)
        dataStrobe |=> !dataStrobe)
        else $error("dataStrobe high on two consecutive cycles");

    // Only reset leaves the halted state
    haltSticky: assert property (@(posedge clk)
        (!halted && $past(halted)) |-> !$past(reset_n))
        else $error("halted fell without reset");

    strobeQuietHalted: assert property (@(posedge clk) disable iff (!reset_n)
        halted |-> !dataStrobe)
        else $error("dataStrobe high while halted");

endmodule

bind cpuCore cpuSystem_props u_props (
    .clk        (clk),
    .reset_n    (reset_n),
    .dataStrobe (dataStrobe),
    .halted     (halted)
);

`default_nettype wire

// File: hdl/cpuSystem.sv
`timescale 1ns/1ns
`default_nettype none

module cpuSystem (
    input  wire logic           clk,
    input  wire logic           reset_n,
    input  wire logic           haltRequest,
    input  wire logic           loadEnable,
    input  wire cpuPkg::word_t  loadAddr,
    input  wire cpuPkg::word_t  loadData,
    output logic                halted,
    output logic                storeStrobe,
    output cpuPkg::word_t       storeAddr,
    output cpuPkg::word_t       storeData
);

    cpuPkg::word_t insnAddr;
    cpuPkg::word_t insnData;
    cpuPkg::word_t dataIn;
    logic          dataStrobe;

    // The write flag is the strobe already qualified by storing
    cpuCore u_core (
        .clk         (clk),
        .reset_n     (reset_n),
        .haltRequest (haltRequest),
        .insnData    (insnData),
        .dataIn      (dataIn),
        .insnAddr    (insnAddr),
        .dataAddr    (storeAddr),
        .dataOut     (storeData),
        .dataStrobe  (dataStrobe),
        .dataWrite   (storeStrobe),
        .halted      (halted)
    );

    wordMemory u_mem (
        .clk        (clk),
        .loadEnable (loadEnable),
        .dataStrobe (dataStrobe),
        .dataWrite  (storeStrobe),
        .loadAddr   (loadAddr),
        .loadData   (loadData),
        .insnAddr   (insnAddr),
        .dataAddr   (storeAddr),
        .dataOut    (storeData),
        .insnData   (insnData),
        .dataIn     (dataIn)
    );

endmodule

`default_nettype wire

// File: hdl/wordMemory.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_macros.svh"

module wordMemory (
    input  wire logic           clk,
    input  wire logic           loadEnable,
    input  wire logic           dataStrobe,
    input  wire logic           dataWrite,
    input  wire cpuPkg::word_t  loadAddr,
    input  wire cpuPkg::word_t  loadData,
    input  wire cpuPkg::word_t  insnAddr,
    input  wire cpuPkg::word_t  dataAddr,
    input  wire cpuPkg::word_t  dataOut,
    output cpuPkg::word_t       insnData,
    output cpuPkg::word_t       dataIn
);

    cpuPkg::word_t mem [0:`MEM_DEPTH-1];

    // Addresses wrap at the memory depth
    logic [`ADDR_BITS-1:0] insnIndex;
    logic [`ADDR_BITS-1:0] dataIndex;
    logic [`ADDR_BITS-1:0] loadIndex;

    assign insnIndex = insnAddr[`ADDR_BITS-1:0];
    assign dataIndex = dataAddr[`ADDR_BITS-1:0];
    assign loadIndex = loadAddr[`ADDR_BITS-1:0];

    assign dataIn = mem[dataIndex];  // Combinational data read

    always_ff @(posedge clk) begin
        insnData <= mem[insnIndex];
        if (loadEnable) begin
            mem[loadIndex] <= loadData;  // Program load, only in reset
        end else if (dataStrobe && dataWrite) begin
            mem[dataIndex] <= dataOut;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cpuCore.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_macros.svh"

module cpuCore (
    input  wire logic           clk,
    input  wire logic           reset_n,
    input  wire logic           haltRequest,
    input  wire cpuPkg::word_t  insnData,
    input  wire cpuPkg::word_t  dataIn,
    output cpuPkg::word_t       insnAddr,
    output cpuPkg::word_t       dataAddr,
    output cpuPkg::word_t       dataOut,
    output logic                dataStrobe,
    output logic                dataWrite,
    output logic                halted
);

    typedef enum logic [2:0] {
        stIdle,
        stFetchWait,
        stExecute,
        stResult,
        stSettle,
        stMemory,
        stWriteBack,
        stHalted
    } state_t;

    state_t state;

    cpuPkg::insn_t fields;
    cpuPkg::word_t immExt;
    logic          illegal;
    logic          branch;
    logic          loading;

    cpuPkg::word_t valueX;
    cpuPkg::word_t valueY;
    cpuPkg::word_t valueZ;
    cpuPkg::word_t rhs;
    cpuPkg::word_t nextPc;
    cpuPkg::word_t resultReg;
    cpuPkg::word_t dataReg;
    cpuPkg::word_t wbValue;
    logic          execEn;
    logic          regWrite;

    insnDecoder u_decoder (
        .insn    (insnData),
        .fields  (fields),
        .immExt  (immExt),
        .illegal (illegal),
        .branch  (branch),
        .loading (loading)
    );

    assign execEn = (state == stExecute);

    execUnit u_exec (
        .clk  (clk),
        .en   (execEn),
        .swap (fields.kind),
        .op   (fields.opcode),
        .x    (valueX),
        .y    (valueY),
        .imm  (immExt),
        .rhs  (rhs)
    );

    // Stores never touch the register file
    assign regWrite = (state == stWriteBack) && !fields.storing;

    regFile u_regs (
        .clk         (clk),
        .writeEnable (regWrite),
        .indexX      (fields.x),
        .indexY      (fields.y),
        .indexZ      (fields.z),
        .writeData   (wbValue),
        .nextPc      (nextPc),
        .valueX      (valueX),
        .valueY      (valueY),
        .valueZ      (valueZ)
    );

    // Six cycles per instruction, fetch wait through write back
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle:      state <= haltRequest ? stIdle : stFetchWait;
                stFetchWait: state <= stExecute;
                stExecute: begin
                    if (haltRequest) begin
                        state <= stIdle;
                    end else if (illegal) begin
                        state <= stHalted;  // Held until reset
                    end else begin
                        state <= stResult;
                    end
                end
                stResult:    state <= stSettle;
                stSettle:    state <= stMemory;   // Multiplier settles
                stMemory:    state <= stWriteBack;
                stWriteBack: state <= stFetchWait;
                default:     state <= stHalted;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            stIdle:      insnAddr  <= `RESET_VECTOR;
            stFetchWait: nextPc    <= insnAddr + 32'd1;
            stResult:    resultReg <= rhs;
            stMemory:    dataReg   <= dataIn;
            stWriteBack: insnAddr  <= branch ? wbValue : nextPc;
            default: ;
        endcase
    end

    // Dereferenced form swaps the roles of the computed value and Z
    assign dataAddr = fields.derefRhs ? resultReg : valueZ;
    assign dataOut  = fields.derefRhs ? valueZ : resultReg;
    assign wbValue  = fields.derefRhs ? dataReg : resultReg;

    assign dataStrobe = (state == stMemory) && (loading || fields.storing);
    assign dataWrite  = dataStrobe && fields.storing;  // Already qualified
    assign halted     = (state == stHalted);

endmodule

`default_nettype wire

// File: hdl/execUnit.sv
`timescale 1ns/1ns
`default_nettype none

module execUnit (
    input  wire logic             clk,
    input  wire logic             en,
    input  wire logic             swap,
    input  wire cpuPkg::opcode_t  op,
    input  wire cpuPkg::word_t    x,
    input  wire cpuPkg::word_t    y,
    input  wire cpuPkg::word_t    imm,
    output cpuPkg::word_t         rhs
);

    cpuPkg::word_t operand;
    cpuPkg::word_t addend;
    cpuPkg::word_t opResult;

    // Swapped form is X op I + Y
    assign operand = swap ? imm : y;
    assign addend  = swap ? y : imm;

    always_comb begin
        case (op)
            cpuPkg::opOr:     opResult = x | operand;
            cpuPkg::opAnd:    opResult = x & operand;
            cpuPkg::opAdd:    opResult = x + operand;
            cpuPkg::opMul:    opResult = x * operand;           // Low half only
            cpuPkg::opShl:    opResult = x << operand;
            // Comparisons are signed, true is all ones
            cpuPkg::opLt:     opResult = {32{$signed(x) < $signed(operand)}};
            cpuPkg::opEq:     opResult = {32{x == operand}};
            cpuPkg::opGt:     opResult = {32{$signed(x) > $signed(operand)}};
            cpuPkg::opAndNot: opResult = x & ~operand;
            cpuPkg::opXor:    opResult = x ^ operand;
            cpuPkg::opSub:    opResult = x - operand;
            cpuPkg::opXnor:   opResult = x ^~ operand;
            cpuPkg::opShr:    opResult = x >> operand;          // Logical
            cpuPkg::opNe:     opResult = {32{x != operand}};
            default:          opResult = '0;                    // Reserved codes
        endcase
    end

    always_ff @(posedge clk) begin
        if (en) begin
            rhs <= opResult + addend;
        end
    end

endmodule

`default_nettype wire

// File: hdl/insnDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module insnDecoder (
    input  wire cpuPkg::word_t insn,
    output cpuPkg::insn_t      fields,
    output cpuPkg::word_t      immExt,
    output logic               illegal,
    output logic               branch,
    output logic               loading
);

    assign fields = cpuPkg::insn_t'(insn);

    // 12-bit immediate to full width
    assign immExt = {{20{fields.imm[11]}}, fields.imm};

    assign illegal = &insn;                          // All-ones word
    assign branch  = (&fields.z) && !fields.storing;  // Writing r15 is a jump

    // A dereferenced non-store reads memory
    assign loading = fields.derefRhs && !fields.storing;

endmodule

`default_nettype wire

// File: hdl/regFile.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_macros.svh"

module regFile (
    input  wire logic              clk,
    input  wire logic              writeEnable,
    input  wire cpuPkg::regIndex_t indexX,
    input  wire cpuPkg::regIndex_t indexY,
    input  wire cpuPkg::regIndex_t indexZ,
    input  wire cpuPkg::word_t     writeData,
    input  wire cpuPkg::word_t     nextPc,
    output cpuPkg::word_t          valueX,
    output cpuPkg::word_t          valueY,
    output cpuPkg::word_t          valueZ
);

    cpuPkg::word_t store [1:14];     // r0 and r15 are not stored

    // r0 reads zero, r15 reads the address of the next instruction
    assign valueX = (indexX == `REG_ZERO) ? '0 :
                    (indexX == `REG_PC)   ? nextPc : store[indexX];
    assign valueY = (indexY == `REG_ZERO) ? '0 :
                    (indexY == `REG_PC)   ? nextPc : store[indexY];
    assign valueZ = (indexZ == `REG_ZERO) ? '0 :
                    (indexZ == `REG_PC)   ? nextPc : store[indexZ];

    always_ff @(posedge clk) begin
        if (writeEnable && indexZ != `REG_ZERO && indexZ != `REG_PC) begin
            store[indexZ] <= writeData;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cpuPkg.sv
`default_nettype none

package cpuPkg;

    typedef logic [31:0] word_t;     // Data, address and instruction word
    typedef logic [3:0] regIndex_t;

    typedef enum logic [3:0] {
        opOr        = 4'd0,
        opAnd       = 4'd1,
        opAdd       = 4'd2,
        opMul       = 4'd3,
        opReserved4 = 4'd4,          // Yields 0 + addend
        opShl       = 4'd5,
        opLt        = 4'd6,
        opEq        = 4'd7,
        opGt        = 4'd8,
        opAndNot    = 4'd9,
        opXor       = 4'd10,
        opSub       = 4'd11,
        opXnor      = 4'd12,
        opShr       = 4'd13,
        opNe        = 4'd14,
        opReserved15 = 4'd15         // Yields 0 + addend
    } opcode_t;

    // Single instruction format, MSB first
    // The top bit doubles as the spare bit
    typedef struct packed {
        logic      reserved;         // Bit 31
        logic      kind;             // Swap Y and immediate roles
        logic      storing;          // Write to memory instead of Z
        logic      derefRhs;         // Computed value is an address
        regIndex_t z;                // Bits 27:24
        regIndex_t x;                // Bits 23:20
        regIndex_t y;                // Bits 19:16
        opcode_t   opcode;           // Bits 15:12
        logic [11:0] imm;            // Sign-extended on use
    } insn_t;

endpackage

`default_nettype wire

// File: hdl/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Memory geometry
`define MEM_DEPTH 4096
`define ADDR_BITS 12

// First instruction address after reset
`define RESET_VECTOR 32'd0

// All-ones word stops the core
`define ILLEGAL_INSN 32'hFFFF_FFFF

// Special register indices
`define REG_PC 4'd15
`define REG_ZERO 4'd0

`endif
